//--- verilog/decodePkg.sv
package decodePkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] regSel_t;
	typedef logic [4:0] opCode_t;
	typedef logic [3:0] aluCtrl_t;

	// Opcode field, inst[15:11]
	localparam opCode_t OP_HALT = 5'b00000;
	localparam opCode_t OP_NOP = 5'b00001;
	localparam opCode_t OP_ADDI = 5'b01000;
	localparam opCode_t OP_SUBI = 5'b01001;
	localparam opCode_t OP_XORI = 5'b01010;
	localparam opCode_t OP_ANDNI = 5'b01011;
	localparam opCode_t OP_ST = 5'b10000;
	localparam opCode_t OP_LD = 5'b10001;
	localparam opCode_t OP_BEQZ = 5'b01100;
	localparam opCode_t OP_BNEZ = 5'b01101;
	localparam opCode_t OP_J = 5'b00100;
	localparam opCode_t OP_JAL = 5'b00110;
	localparam opCode_t OP_LBI = 5'b11000;
	localparam opCode_t OP_SLBI = 5'b10010;
	localparam opCode_t OP_ALU = 5'b11011;

	// ALU operations, the first four match the OP_ALU function bits
	localparam aluCtrl_t ALU_ADD = 4'h0;
	localparam aluCtrl_t ALU_SUB = 4'h1;
	localparam aluCtrl_t ALU_XOR = 4'h2;
	localparam aluCtrl_t ALU_ANDN = 4'h3;
	localparam aluCtrl_t ALU_PASSA = 4'h4;
	localparam aluCtrl_t ALU_PASSB = 4'h5;
	localparam aluCtrl_t ALU_SLBI = 4'h6;

	typedef struct packed {
		logic regWrite;
		logic dMemWrite;
		logic dMemEn;
		logic pcSrc;
		logic pcImm;
		logic jump;
		logic dMemDump;
		logic memToReg;
		logic writeDataSel;
		logic aluSrc2;
		aluCtrl_t aluCtrl;
		logic [1:0] opCode1_0;
	} ctrl_t;

	// One later stage's pending register write
	typedef struct packed {
		regSel_t regSel;
		logic regWrite;
	} pendWrite_t;

endpackage

//--- verilog/controlDecoder.sv
module controlDecoder (
	input decodePkg::word_t inst,
	output decodePkg::ctrl_t rawCtrl,
	output decodePkg::regSel_t writeRegSel,
	output decodePkg::word_t immExt,
	output logic illegal
);

	decodePkg::opCode_t opCode;
	decodePkg::word_t zExt5;
	decodePkg::word_t sExt5;
	decodePkg::word_t zExt8;
	decodePkg::word_t sExt8;
	decodePkg::word_t sExt11;

	assign opCode = inst[15:11];

	// Candidate immediates
	assign zExt5 = {11'b0, inst[4:0]};
	assign sExt5 = {{11{inst[4]}}, inst[4:0]};
	assign zExt8 = {8'b0, inst[7:0]};
	assign sExt8 = {{8{inst[7]}}, inst[7:0]};
	assign sExt11 = {{5{inst[10]}}, inst[10:0]};

	always_comb begin
		rawCtrl = '0;
		writeRegSel = '0;
		immExt = '0;
		illegal = 1'b0;
		case (opCode)
			decodePkg::OP_HALT: begin
				rawCtrl.dMemDump = 1'b1;
			end
			decodePkg::OP_NOP: begin
				rawCtrl.aluCtrl = decodePkg::ALU_ADD;
			end
			decodePkg::OP_ADDI, decodePkg::OP_SUBI: begin
				rawCtrl.regWrite = 1'b1;
				rawCtrl.aluSrc2 = 1'b1;
				rawCtrl.aluCtrl = opCode[0] ? decodePkg::ALU_SUB : decodePkg::ALU_ADD;
				writeRegSel = inst[7:5];
				immExt = sExt5;
			end
			decodePkg::OP_XORI, decodePkg::OP_ANDNI: begin
				rawCtrl.regWrite = 1'b1;
				rawCtrl.aluSrc2 = 1'b1;
				rawCtrl.aluCtrl = opCode[0] ? decodePkg::ALU_ANDN : decodePkg::ALU_XOR;
				writeRegSel = inst[7:5];
				immExt = zExt5;
			end
			decodePkg::OP_ST: begin
				rawCtrl.dMemWrite = 1'b1;
				rawCtrl.dMemEn = 1'b1;
				rawCtrl.aluSrc2 = 1'b1;
				rawCtrl.aluCtrl = decodePkg::ALU_ADD;
				immExt = sExt5;
			end
			decodePkg::OP_LD: begin
				rawCtrl.regWrite = 1'b1;
				rawCtrl.dMemEn = 1'b1;
				rawCtrl.memToReg = 1'b1;
				rawCtrl.aluSrc2 = 1'b1;
				rawCtrl.aluCtrl = decodePkg::ALU_ADD;
				writeRegSel = inst[7:5];
				immExt = sExt5;
			end
			decodePkg::OP_BEQZ, decodePkg::OP_BNEZ: begin
				// Condition on Rs is resolved in execute
				rawCtrl.pcSrc = 1'b1;
				rawCtrl.pcImm = 1'b1;
				rawCtrl.aluCtrl = decodePkg::ALU_PASSA;
				immExt = sExt8;
			end
			decodePkg::OP_J: begin
				rawCtrl.jump = 1'b1;
				rawCtrl.pcImm = 1'b1;
				immExt = sExt11;
			end
			decodePkg::OP_JAL: begin
				rawCtrl.jump = 1'b1;
				rawCtrl.pcImm = 1'b1;
				rawCtrl.regWrite = 1'b1;
				rawCtrl.writeDataSel = 1'b1;
				writeRegSel = 3'd7;
				immExt = sExt11;
			end
			decodePkg::OP_LBI, decodePkg::OP_SLBI: begin
				rawCtrl.regWrite = 1'b1;
				rawCtrl.aluSrc2 = 1'b1;
				rawCtrl.aluCtrl = decodePkg::ALU_PASSB;
				writeRegSel = inst[10:8];
				// Only LBI sign extends its byte
				immExt = opCode[3] ? sExt8 : zExt8;
			end
			decodePkg::OP_ALU: begin
				rawCtrl.regWrite = 1'b1;
				rawCtrl.aluCtrl = {2'b00, inst[1:0]};
				writeRegSel = inst[4:2];
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
		if (!illegal)
			rawCtrl.opCode1_0 = opCode[1:0];
	end

	always_comb begin
		if (illegal)
			assert (!rawCtrl.regWrite && !rawCtrl.dMemWrite)
				else $error("illegal opcode %b decoded with a write enabled", opCode);
	end

endmodule

//--- verilog/regFile.sv
module regFile (
	input logic clk,
	input logic reset,
	input decodePkg::regSel_t readSel1,
	input decodePkg::regSel_t readSel2,
	input decodePkg::pendWrite_t write,
	input decodePkg::word_t writeData,
	output decodePkg::word_t readData1,
	output decodePkg::word_t readData2
);

	decodePkg::word_t regs [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (write.regWrite) begin
			regs[write.regSel] <= writeData;
		end
	end

	// No bypass, a reader of a register in flight is stalled
	assign readData1 = regs[readSel1];
	assign readData2 = regs[readSel2];

	assertWriteKnown: assert property (@(posedge clk) disable iff (reset)
		write.regWrite |-> !$isunknown({write.regSel, writeData}))
		else $error("register write with unknown select or data");

endmodule

//--- verilog/hazardGate.sv
module hazardGate (
	input decodePkg::regSel_t srcSel1,
	input decodePkg::regSel_t srcSel2,
	input decodePkg::pendWrite_t idExWrite,
	input decodePkg::pendWrite_t exMemWrite,
	input decodePkg::pendWrite_t memWbWrite,
	input decodePkg::ctrl_t rawCtrl,
	output logic stall,
	output decodePkg::ctrl_t ctrl
);

	function automatic logic pendingOn(decodePkg::regSel_t sel, decodePkg::pendWrite_t pw);
		return pw.regWrite && (pw.regSel == sel);
	endfunction

	// No forwarding, any match stalls
	assign stall = pendingOn(srcSel1, idExWrite) | pendingOn(srcSel2, idExWrite) |
		pendingOn(srcSel1, exMemWrite) | pendingOn(srcSel2, exMemWrite) |
		pendingOn(srcSel1, memWbWrite) | pendingOn(srcSel2, memWbWrite);

	always_comb begin
		ctrl = rawCtrl;
		if (stall) begin
			ctrl.regWrite = 1'b0;
			ctrl.dMemWrite = 1'b0;
			ctrl.dMemEn = 1'b0;
			ctrl.pcSrc = 1'b0;
			ctrl.pcImm = 1'b0;
			ctrl.jump = 1'b0;
			ctrl.dMemDump = 1'b0;
		end
	end

	always_comb begin
		if (stall)
			assert ({ctrl.regWrite, ctrl.dMemWrite, ctrl.dMemEn, ctrl.pcSrc,
				ctrl.pcImm, ctrl.jump, ctrl.dMemDump} == 7'b0)
				else $error("side effect control leaked through a stall");
	end

endmodule

//--- verilog/decodeStage.sv
module decodeStage (
	input logic clk,
	input logic reset,
	input decodePkg::word_t inst,
	input decodePkg::pendWrite_t wbWrite,
	input decodePkg::word_t writeData,
	input decodePkg::pendWrite_t idExWrite,
	input decodePkg::pendWrite_t exMemWrite,
	input decodePkg::pendWrite_t memWbWrite,
	output decodePkg::ctrl_t ctrl,
	output decodePkg::regSel_t writeRegSel,
	output decodePkg::word_t readData1,
	output decodePkg::word_t readData2,
	output decodePkg::word_t immExt,
	output logic stall,
	output logic illegal
);

	decodePkg::ctrl_t rawCtrl;

	controlDecoder i_controlDecoder (
		.inst(inst),
		.rawCtrl(rawCtrl),
		.writeRegSel(writeRegSel),
		.immExt(immExt),
		.illegal(illegal)
	);

	// Source fields Rs and Rt
	regFile i_regFile (
		.clk(clk),
		.reset(reset),
		.readSel1(inst[10:8]),
		.readSel2(inst[7:5]),
		.write(wbWrite),
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2)
	);

	hazardGate i_hazardGate (
		.srcSel1(inst[10:8]),
		.srcSel2(inst[7:5]),
		.idExWrite(idExWrite),
		.exMemWrite(exMemWrite),
		.memWbWrite(memWbWrite),
		.rawCtrl(rawCtrl),
		.stall(stall),
		.ctrl(ctrl)
	);

endmodule

//--- verif/clockGen.sv
module clockGen (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod = 20;
	localparam int resetCycles = 16;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Released just after an edge, like the other stimulus
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#2 reset = 1'b0;
	end

endmodule

//--- verif/decodeStageTb.sv
module decodeStageTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 16;
	localparam int driveDelay = 2;
	localparam int checkDelay = 36;
	localparam string vectorPath = "verif/decodeVectors.txt";

	logic clk;
	logic reset;
	decodePkg::word_t inst;
	decodePkg::pendWrite_t wbWrite;
	decodePkg::word_t writeData;
	decodePkg::pendWrite_t idExWrite;
	decodePkg::pendWrite_t exMemWrite;
	decodePkg::pendWrite_t memWbWrite;
	decodePkg::ctrl_t ctrl;
	decodePkg::regSel_t writeRegSel;
	decodePkg::word_t readData1;
	decodePkg::word_t readData2;
	decodePkg::word_t immExt;
	logic stall;
	logic illegal;

	integer seed = 32'hb948a6e7;
	int cycles = 0;
	int limit = 0;
	int record = 0;

	clockGen i_clockGen (
		.clk(clk),
		.reset(reset)
	);

	decodeStage i_dut (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.wbWrite(wbWrite),
		.writeData(writeData),
		.idExWrite(idExWrite),
		.exMemWrite(exMemWrite),
		.memWbWrite(memWbWrite),
		.ctrl(ctrl),
		.writeRegSel(writeRegSel),
		.readData1(readData1),
		.readData2(readData2),
		.immExt(immExt),
		.stall(stall),
		.illegal(illegal)
	);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkField(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("ERROR at %0t ns: record %0d, %s is %h, expected %h",
				$time, record, name, got, exp);
			abortRun("output mismatch");
		end
	endtask

	task automatic openVectors(output int fd);
		fd = $fopen(vectorPath, "r");
		if (fd == 0)
			abortRun("could not open the vector file verif/decodeVectors.txt");
	endtask

	// Consume the rest of the current line
	task automatic skipLine(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1)
			c = $fgetc(fd);
	endtask

	task automatic countVectors(output int count);
		int fd;
		int code;
		logic [7:0] kind;
		count = 0;
		openVectors(fd);
		code = $fscanf(fd, " %c", kind);
		while (code == 1) begin
			if (kind != "#")
				count++;
			skipLine(fd);
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
	endtask

	task automatic applyWrite(input int fd);
		logic weIn;
		logic [2:0] selIn;
		logic [15:0] dataIn;
		int code;
		code = $fscanf(fd, "%h %h %h", weIn, selIn, dataIn);
		if (code != 3)
			abortRun("a write line in the vector file is malformed");
		@(posedge clk);
		#driveDelay;
		wbWrite = {selIn, weIn};
		writeData = dataIn;
	endtask

	task automatic applyDecode(input int fd);
		logic [15:0] instIn;
		logic [3:0] pendIdEx;
		logic [3:0] pendExMem;
		logic [3:0] pendMemWb;
		logic [15:0] expCtrl;
		logic [2:0] expSel;
		logic [15:0] expImm;
		logic expStall;
		logic expIllegal;
		logic [15:0] expRead1;
		logic [15:0] expRead2;
		int code;
		code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", instIn, pendIdEx,
			pendExMem, pendMemWb, expCtrl, expSel, expImm, expStall, expIllegal,
			expRead1, expRead2);
		if (code != 11)
			abortRun("a decode line in the vector file is malformed");
		// Bits 4:0 are unused by HALT and NOP
		if (instIn[15:11] == decodePkg::OP_HALT || instIn[15:11] == decodePkg::OP_NOP)
			instIn[4:0] = 5'($random(seed));
		@(posedge clk);
		#driveDelay;
		inst = instIn;
		idExWrite = pendIdEx;
		exMemWrite = pendExMem;
		memWbWrite = pendMemWb;
		wbWrite = '0;
		writeData = '0;
		#checkDelay;
		checkField("ctrl", ctrl, expCtrl);
		checkField("writeRegSel", 16'(writeRegSel), 16'(expSel));
		checkField("immExt", immExt, expImm);
		checkField("stall", 16'(stall), 16'(expStall));
		checkField("illegal", 16'(illegal), 16'(expIllegal));
		checkField("readData1", readData1, expRead1);
		checkField("readData2", readData2, expRead2);
	endtask

	initial begin
		int fd;
		int total;
		int code;
		logic [7:0] kind;
		inst = '0;
		wbWrite = '0;
		writeData = '0;
		idExWrite = '0;
		exMemWrite = '0;
		memWbWrite = '0;
		countVectors(total);
		limit = resetCycles + 2 * total + 20;
		openVectors(fd);
		@(negedge reset);
		code = $fscanf(fd, " %c", kind);
		while (code == 1) begin
			if (kind == "#") begin
				skipLine(fd);
			end else if (kind == "W") begin
				record++;
				applyWrite(fd);
			end else if (kind == "D") begin
				record++;
				applyDecode(fd);
			end else begin
				abortRun("the vector file holds a line of unknown kind");
			end
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
		$display("TEST PASS");
		$finish;
	end

	// Watchdog
	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the vectors did not finish", cycles);
		abortRun("run timed out");
	end

endmodule

//--- verif/decodeVectors.txt
# W regWrite reg data
# D inst idEx exMem memWb ctrl writeRegSel immExt stall illegal readData1 readData2
# All hex, pending writes are {regSel, regWrite}
D D828 0 0 0 8003 2 0000 0 0 0000 0000
D DA75 0 0 0 8007 5 0000 0 0 0000 0000
D DCBE 0 0 0 800B 7 0000 0 0 0000 0000
D DEE7 0 0 0 800F 1 0000 0 0 0000 0000
D 0380 0 0 0 0200 0 0000 0 0 0000 0000
D 09C0 0 0 0 0001 0 0000 0 0 0000 0000
D 4153 0 0 0 8040 2 FFF3 0 0 0000 0000
D 4B85 0 0 0 8045 4 0005 0 0 0000 0000
D 55DF 0 0 0 804A 6 001F 0 0 0000 0000
D 5830 0 0 0 804F 1 0010 0 0 0000 0000
D 827E 0 0 0 6040 0 FFFE 0 0 0000 0000
D 8CA7 0 0 0 A141 5 0007 0 0 0000 0000
D 6680 0 0 0 1810 0 FF80 0 0 0000 0000
D 6F3C 0 0 0 1811 0 003C 0 0 0000 0000
D 27F0 0 0 0 0C00 0 FFF0 0 0 0000 0000
D 3123 0 0 0 8C82 7 0123 0 0 0000 0000
D C3A5 0 0 0 8054 3 FFA5 0 0 0000 0000
D 965A 0 0 0 8056 6 005A 0 0 0000 0000
D F812 0 0 0 0000 0 0000 0 1 0000 0000
W 1 3 BEEF
D DB60 0 0 0 8003 0 0000 0 0 BEEF BEEF
W 1 5 1234
W 0 5 FFFF
D DD66 0 0 0 800B 1 0000 0 0 1234 BEEF
W 1 0 8001
D 40A1 0 0 0 8040 5 0001 0 0 8001 1234
D 827E 5 0 0 0040 0 FFFE 1 0 0000 BEEF
D DD66 7 0 0 000B 1 0000 1 0 1234 BEEF
D 3123 0 3 0 0082 7 0123 1 0 0000 0000
D 4B85 0 7 0 0045 4 0005 1 0 BEEF 0000
D DB60 0 7 0 0003 0 0000 1 0 BEEF BEEF
D 0380 0 0 9 0000 0 0000 1 0 BEEF 0000
D 8CA7 0 0 B 0141 5 0007 1 0 0000 1234
D 40A1 0 0 1 0040 5 0001 1 0 8001 1234
D 27F0 0 0 F 0000 0 FFF0 1 0 0000 0000
D 6680 D 0 0 0010 0 FF80 1 0 0000 0000
D DB60 6 6 6 8003 0 0000 0 0 BEEF BEEF
D DB60 F B 1 8003 0 0000 0 0 BEEF BEEF

//--- compile.f
verilog/decodePkg.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/hazardGate.sv
verilog/decodeStage.sv
verif/clockGen.sv
verif/decodeStageTb.sv

//--- Makefile
TOP = decodeStageTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --top-module $(TOP) -f compile.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
